// ==== Makefile ====
TOP = neuron_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^Regression passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== common/fp_op_if.sv ====
`timescale 1ns/10ps

interface fp_op_if
	import node_pkg::*;
();

	logic  op_valid;  // Operands valid this cycle.
	fp32_t op_a;
	fp32_t op_b;
	logic  res_valid; // One cycle after op_valid.
	fp32_t res;

	modport issuer
	(
		output op_valid,
		output op_a,
		output op_b,
		input  res_valid,
		input  res
	);

	modport unit
	(
		input  op_valid,
		input  op_a,
		input  op_b,
		output res_valid,
		output res
	);

endinterface

// ==== common/node_macros.svh ====
`ifndef NODE_MACROS_SVH
`define NODE_MACROS_SVH

// Weighted inputs per neuron.
`define NODE_INPUTS 15

// Weight store address width, the word above the last weight holds the bias.
`define NODE_ADDR_W 4

// Single-precision exponent bias.
`define FP_EXP_BIAS 127

`endif

// ==== common/node_pkg.sv ====
package node_pkg;

	// Raw single-precision word as it travels on buses and ports.
	typedef logic [31:0] fp32_t;

	// Field view of an fp32_t word.
	typedef struct packed
	{
		logic        sign;
		logic [7:0]  exp;  // Biased exponent, zero means zero or flushed subnormal.
		logic [22:0] man;  // Fraction without the hidden one.
	} fp_fields_t;

	// Neuron controller states.
	typedef enum logic [1:0]
	{
		st_idle,  // Waiting for the first sample.
		st_accum, // Taking samples and summing products.
		st_bias,  // All samples taken, bias add pending.
		st_rect   // Final sum on the adder output.
	} node_state_t;

endpackage

// ==== design/neuron_ctrl.sv ====
`timescale 1ns/10ps
`include "node_macros.svh"

module neuron_ctrl
	import node_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    x_valid,
	input  fp32_t                   x_data,
	output logic [`NODE_ADDR_W-1:0] rd_addr,
	input  fp32_t                   rd_data,
	fp_op_if.issuer                 mul,
	fp_op_if.issuer                 add,
	output logic                    y_valid,
	output fp32_t                   y_data,
	output logic                    busy
);

	localparam int addr_w = `NODE_ADDR_W;
	localparam logic [addr_w-1:0] last_idx = addr_w'(`NODE_INPUTS - 1);
	localparam logic [addr_w-1:0] bias_addr = addr_w'(`NODE_INPUTS);

	node_state_t state;
	logic [addr_w-1:0] cnt;
	logic accept;
	logic accept_last;
	logic smp_v;
	logic mul_v;
	logic [3:0] last_sr;
	logic bias_go;
	fp32_t x_q;
	fp32_t x_d;
	fp32_t acc_q;
	fp32_t acc_cur;
	fp_fields_t sum_f;

	assign accept = x_valid && (state == st_idle || state == st_accum);
	assign accept_last = accept && (cnt == last_idx);
	assign bias_go = last_sr[3]; // Last product has just reached the accumulator.
	assign busy = (state != st_idle);

	// Sample meets its weight one cycle after the read address.
	assign mul.op_valid = mul_v;
	assign mul.op_a = x_d;
	assign mul.op_b = rd_data;

	// Forward the adder result so samples can come every cycle.
	assign acc_cur = add.res_valid ? add.res : acc_q;
	assign add.op_valid = mul.res_valid || bias_go;
	assign add.op_a = bias_go ? rd_data : mul.res;
	assign add.op_b = acc_cur;

	assign sum_f = add.res;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			cnt <= '0;
			smp_v <= 1'b0;
			mul_v <= 1'b0;
			last_sr <= '0;
			acc_q <= '0;
			y_valid <= 1'b0;
		end
		else
		begin
			smp_v <= accept;
			mul_v <= smp_v;
			last_sr <= {last_sr[2:0], accept_last};
			y_valid <= 1'b0;

			if (state == st_rect)
			begin
				acc_q <= '0;
			end
			else if (add.res_valid)
			begin
				acc_q <= add.res;
			end

			case (state)
				st_idle, st_accum:
				begin
					if (accept)
					begin
						cnt <= cnt + 1'b1;
						state <= accept_last ? st_bias : st_accum;
					end
				end
				st_bias:
				begin
					if (bias_go)
					begin
						state <= st_rect;
					end
				end
				st_rect:
				begin
					cnt <= '0;
					y_valid <= 1'b1;
					state <= st_idle;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		x_d <= x_q;
		if (accept)
		begin
			x_q <= x_data;
			rd_addr <= cnt;
		end
		else if (state == st_bias)
		begin
			rd_addr <= bias_addr; // Bias sits above the weights.
		end
		if (state == st_rect)
		begin
			y_data <= sum_f.sign ? '0 : add.res; // Rectifier.
		end
	end

endmodule

// ==== design/neuron_top.sv ====
`timescale 1ns/10ps
`include "node_macros.svh"

module neuron_top
	import node_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    w_wr,
	input  logic [`NODE_ADDR_W-1:0] w_addr,
	input  fp32_t                   w_data,
	input  logic                    x_valid,
	input  fp32_t                   x_data,
	output logic                    y_valid,
	output fp32_t                   y_data,
	output logic                    busy
);

	logic [`NODE_ADDR_W-1:0] rd_addr;
	fp32_t rd_data;

	fp_op_if mul_op ();
	fp_op_if add_op ();

	weight_ram i_weight_ram
	(
		.clk     (clk),
		.w_wr    (w_wr),
		.w_addr  (w_addr),
		.w_data  (w_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	neuron_ctrl i_neuron_ctrl
	(
		.clk     (clk),
		.rst     (rst),
		.x_valid (x_valid),
		.x_data  (x_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.mul     (mul_op),
		.add     (add_op),
		.y_valid (y_valid),
		.y_data  (y_data),
		.busy    (busy)
	);

	fp_mult i_fp_mult
	(
		.clk (clk),
		.rst (rst),
		.op  (mul_op)
	);

	fp_add i_fp_add
	(
		.clk (clk),
		.rst (rst),
		.op  (add_op)
	);

endmodule

// ==== design/weight_ram.sv ====
`timescale 1ns/10ps
`include "node_macros.svh"

module weight_ram
	import node_pkg::*;
(
	input  logic                    clk,
	input  logic                    w_wr,
	input  logic [`NODE_ADDR_W-1:0] w_addr,
	input  fp32_t                   w_data,
	input  logic [`NODE_ADDR_W-1:0] rd_addr,
	output fp32_t                   rd_data
);

	localparam int depth = 2 ** `NODE_ADDR_W;

	fp32_t mem [depth];

	always_ff @(posedge clk)
	begin
		if (w_wr)
		begin
			mem[w_addr] <= w_data;
		end
	end

	// One cycle read latency.
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== fp_add/fp_add.sv ====
`timescale 1ns/10ps
`include "node_macros.svh"

module fp_add
	import node_pkg::*;
(
	input  logic clk,
	input  logic rst,
	fp_op_if.unit op
);

	localparam int exp_max = 2 * `FP_EXP_BIAS + 1;

	fp_fields_t a;
	fp_fields_t b;
	fp_fields_t big;
	fp_fields_t sml;
	fp_fields_t r;
	logic swap;
	logic [23:0] big_m;
	logic [23:0] sml_m;
	logic [7:0] exp_d;
	logic [26:0] big_x;
	logic [26:0] sml_x;
	logic [27:0] sum;
	logic [4:0] lz;
	logic [26:0] norm;
	logic signed [9:0] exp_r;
	logic [22:0] man_r;

	// Leading zeros of the uncarried sum, 27 when it is all zero.
	function automatic logic [4:0] lead_zeros(input logic [26:0] v);
		logic [4:0] n;
		logic found;
		n = 5'd27;
		found = 1'b0;
		for (int i = 26; i >= 0; i--)
		begin
			if (!found && v[i])
			begin
				n = 5'(26 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	always_comb
	begin
		a = op.op_a;
		b = op.op_b;

		swap = op.op_b[30:0] > op.op_a[30:0]; // Magnitude order from the raw bits.
		big = swap ? b : a;
		sml = swap ? a : b;

		big_m = (big.exp != 8'd0) ? {1'b1, big.man} : 24'd0;
		sml_m = (sml.exp != 8'd0) ? {1'b1, sml.man} : 24'd0;
		exp_d = big.exp - sml.exp;

		big_x = {big_m, 3'b000}; // Three guard bits below the fraction.
		sml_x = {sml_m, 3'b000} >> exp_d;

		if (big.sign == sml.sign)
		begin
			sum = {1'b0, big_x} + {1'b0, sml_x};
		end
		else
		begin
			sum = {1'b0, big_x} - {1'b0, sml_x};
		end

		lz = lead_zeros(sum[26:0]);
		norm = sum[26:0] << lz;

		if (sum[27])
		begin
			man_r = sum[26:4]; // Carry out, shift right by one.
			exp_r = 10'(big.exp) + 10'sd1;
		end
		else
		begin
			man_r = norm[25:3];
			exp_r = 10'(big.exp) - 10'(lz);
		end

		r.sign = big.sign;
		r.exp = exp_r[7:0];
		r.man = man_r;
		if (sum == 28'd0)
		begin
			r = '0; // Exact cancellation is +0.
		end
		else if (exp_r <= 10'sd0)
		begin
			r.exp = 8'd0;
			r.man = 23'd0;
		end
		else if (exp_r >= 10'(exp_max))
		begin
			r.exp = 8'(exp_max);
			r.man = 23'd0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			op.res_valid <= 1'b0;
		end
		else
		begin
			op.res_valid <= op.op_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (op.op_valid)
		begin
			op.res <= r;
		end
	end

endmodule

// ==== fp_mult/fp_mult.sv ====
`timescale 1ns/10ps
`include "node_macros.svh"

module fp_mult
	import node_pkg::*;
(
	input  logic clk,
	input  logic rst,
	fp_op_if.unit op
);

	localparam int exp_bias = `FP_EXP_BIAS;
	localparam int exp_max = 2 * exp_bias + 1;

	fp_fields_t a;
	fp_fields_t b;
	fp_fields_t r;
	logic zero_in;
	logic [47:0] prod;
	logic norm;
	logic signed [9:0] exp_r;
	logic [22:0] man_r;

	always_comb
	begin
		a = op.op_a;
		b = op.op_b;
		zero_in = (a.exp == 8'd0) || (b.exp == 8'd0); // Subnormals count as zero.

		prod = {1'b1, a.man} * {1'b1, b.man};
		norm = prod[47]; // Product of two 1.x values is below 4.
		man_r = norm ? prod[46:24] : prod[45:23];

		exp_r = 10'(a.exp) + 10'(b.exp) + 10'(norm) - 10'(exp_bias);

		r.sign = a.sign ^ b.sign;
		if (zero_in || exp_r <= 10'sd0)
		begin
			r.exp = 8'd0;
			r.man = 23'd0;
		end
		else if (exp_r >= 10'(exp_max))
		begin
			r.exp = 8'(exp_max); // Signed infinity.
			r.man = 23'd0;
		end
		else
		begin
			r.exp = exp_r[7:0];
			r.man = man_r;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			op.res_valid <= 1'b0;
		end
		else
		begin
			op.res_valid <= op.op_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (op.op_valid)
		begin
			op.res <= r;
		end
	end

endmodule

// ==== tests/neuron_props.sv ====
`timescale 1ns/10ps
`include "node_macros.svh"

module neuron_props
(
	input logic clk,
	input logic rst,
	input logic x_valid,
	input logic y_valid,
	input logic busy
);

	logic [4:0] taken;
	logic fresh;
	logic last_strobe;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			taken <= '0;
			fresh <= 1'b1;
		end
		else
		begin
			if (x_valid)
			begin
				fresh <= 1'b0;
			end
			if (y_valid)
			begin
				taken <= {4'd0, x_valid}; // A strobe with the pulse starts the next vector.
			end
			else if (x_valid && taken < 5'(`NODE_INPUTS))
			begin
				taken <= taken + 1'b1;
			end
		end
	end

	assign last_strobe = x_valid && !y_valid && (taken == 5'(`NODE_INPUTS - 1));

	a_one_pulse: assert property (@(posedge clk) disable iff (rst) y_valid |=> !y_valid)
		else $error("y_valid high for two cycles in a row");

	// Pulse is registered on the fifth edge after the strobe edge.
	a_latency: assert property (@(posedge clk) disable iff (rst) last_strobe |-> ##6 y_valid)
		else $error("y_valid not registered five cycles after the last sample");

	a_idle: assert property (@(posedge clk) disable iff (rst) fresh |-> !busy)
		else $error("busy high before the first sample");

endmodule

bind neuron_top neuron_props i_neuron_props
(
	.clk     (clk),
	.rst     (rst),
	.x_valid (x_valid),
	.y_valid (y_valid),
	.busy    (busy)
);

// ==== tests/neuron_tb.sv ====
`timescale 1ns/10ps
`include "node_macros.svh"

module neuron_tb
	import node_pkg::*;
();

	localparam int n_in = `NODE_INPUTS;

	logic clk;
	logic rst;
	logic w_wr;
	logic [`NODE_ADDR_W-1:0] w_addr;
	fp32_t w_data;
	logic x_valid;
	fp32_t x_data;
	logic y_valid;
	fp32_t y_data;
	logic busy;

	int w_q [n_in]; // Weights in quarters.
	int x_q [n_in]; // Samples in quarters.
	int b_q;
	int errors;
	int checks;
	logic [31:0] lfsr;
	fp32_t y;

	neuron_top i_neuron_top
	(
		.clk     (clk),
		.rst     (rst),
		.w_wr    (w_wr),
		.w_addr  (w_addr),
		.w_data  (w_data),
		.x_valid (x_valid),
		.x_data  (x_data),
		.y_valid (y_valid),
		.y_data  (y_data),
		.busy    (busy)
	);

	always #4 clk = ~clk;

	// Value in sixteenths to a single-precision pattern.
	function automatic fp32_t to_fp(input int s16);
		int mag;
		int p;
		logic [31:0] m;
		if (s16 == 0)
		begin
			return 32'h0;
		end
		mag = (s16 < 0) ? -s16 : s16;
		p = 0;
		for (int i = 0; i < 31; i++)
		begin
			if ((mag >> i) != 0)
			begin
				p = i; // Leading one position.
			end
		end
		m = (p <= 23) ? (32'(mag) << (23 - p)) : (32'(mag) >> (p - 23));
		return {(s16 < 0), 8'(p - 4 + `FP_EXP_BIAS), m[22:0]};
	endfunction

	// Weighted sum in sixteenths, bias, then the rectifier.
	function automatic fp32_t model_out();
		int s;
		s = 4 * b_q;
		for (int i = 0; i < n_in; i++)
		begin
			s += w_q[i] * x_q[i];
		end
		return to_fp((s < 0) ? 0 : s);
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // x^32+x^22+x^2+x+1.
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic int rand_weight();
		int neg;
		int mag;
		neg = take_bits(1);
		mag = 2 << (take_bits(2) % 3); // 0.5, 1 or 2.
		return (neg != 0) ? -mag : mag;
	endfunction

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	endtask

	task automatic check(input string name, input fp32_t exp, input fp32_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic load_weights();
		for (int i = 0; i <= n_in; i++)
		begin
			@(posedge clk);
			w_wr <= 1'b1;
			w_addr <= `NODE_ADDR_W'(i);
			w_data <= to_fp(4 * ((i < n_in) ? w_q[i] : b_q)); // Bias goes last.
		end
		@(posedge clk);
		w_wr <= 1'b0;
	endtask

	task automatic run_vector(input string name, input bit gaps, output fp32_t res);
		int idle;
		int n;
		bit got;
		for (int i = 0; i < n_in; i++)
		begin
			idle = gaps ? take_bits(2) : 0;
			repeat (idle)
			begin
				@(posedge clk);
				x_valid <= 1'b0;
			end
			@(posedge clk);
			x_valid <= 1'b1;
			x_data <= to_fp(4 * x_q[i]);
		end
		@(posedge clk);
		x_valid <= 1'b0;
		got = 1'b0;
		n = 0;
		while (!got && n < 100)
		begin
			@(negedge clk);
			got = y_valid;
			n++;
		end
		if (!got)
		begin
			errors++;
			$display("Timeout in %s: no result arrived within 100 cycles", name);
			finish_run();
		end
		else
		begin
			res = y_data;
			if (busy)
			begin
				errors++;
				$display("In %s busy was still high with the result", name);
			end
		end
	endtask

	task automatic test_plain_sum();
		for (int i = 0; i < n_in; i++)
		begin
			w_q[i] = 4;
			x_q[i] = 4 * (i + 1);
		end
		b_q = 0;
		load_weights();
		run_vector("plain_sum", 1'b0, y);
		check("plain_sum", 32'h42f0_0000, y); // 120.0
	endtask

	task automatic test_rectifier();
		for (int i = 0; i < n_in; i++)
		begin
			w_q[i] = 4;
			x_q[i] = -4;
		end
		b_q = -4;
		load_weights();
		run_vector("rect_negative", 1'b0, y);
		check("rect_negative", 32'h0, y);
		for (int i = 0; i < n_in; i++)
		begin
			w_q[i] = (i < 7) ? 4 : ((i < 14) ? -4 : 0);
			x_q[i] = 4;
		end
		b_q = 0;
		load_weights();
		run_vector("rect_cancel", 1'b0, y);
		check("rect_cancel", 32'h0, y);
	endtask

	task automatic test_mixed();
		int wv [4] = '{2, -2, 8, -8};
		int xv [4] = '{1, -12, -1, 12};
		for (int i = 0; i < n_in; i++)
		begin
			w_q[i] = wv[i % 4];
			x_q[i] = xv[(i + i / 4) % 4];
		end
		b_q = 7;
		load_weights();
		run_vector("mixed", 1'b0, y);
		check("mixed", model_out(), y);
	endtask

	task automatic test_strobe_timing();
		for (int i = 0; i < n_in; i++)
		begin
			x_q[i] = 4 * (i % 7) - 12;
		end
		run_vector("gaps", 1'b1, y);
		check("gaps", model_out(), y);
		run_vector("back_to_back", 1'b0, y);
		check("back_to_back", model_out(), y);
	endtask

	task automatic test_reload();
		for (int i = 0; i < n_in; i++)
		begin
			w_q[i] = 8;
			x_q[i] = i - 5;
		end
		b_q = -14;
		load_weights();
		run_vector("reload", 1'b0, y);
		check("reload", model_out(), y);
	endtask

	task automatic test_random();
		string name;
		for (int k = 0; k < 20; k++)
		begin
			name = $sformatf("random_%0d", k);
			for (int i = 0; i < n_in; i++)
			begin
				w_q[i] = rand_weight();
				x_q[i] = 4 * (take_bits(4) - 8);
			end
			b_q = 4 * (take_bits(4) - 8);
			load_weights();
			run_vector(name, take_bits(1) != 0, y);
			check(name, model_out(), y);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		w_wr = 1'b0;
		w_addr = '0;
		w_data = '0;
		x_valid = 1'b0;
		x_data = '0;
		errors = 0;
		checks = 0;
		lfsr = 32'h6d71_6e24;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		test_plain_sum();
		test_rectifier();
		test_mixed();
		test_strobe_timing();
		test_reload();
		test_random();
		finish_run();
	end

endmodule

// ==== vlog.f ====
+incdir+common
common/node_pkg.sv
common/fp_op_if.sv
fp_mult/fp_mult.sv
fp_add/fp_add.sv
design/weight_ram.sv
design/neuron_ctrl.sv
design/neuron_top.sv
tests/neuron_props.sv
tests/neuron_tb.sv
